//--- compile.f
+incdir+verilog
verilog/layer_pkg.sv
verilog/neuron.sv
verilog/layer_neurons.sv
verilog/layer_output.sv
verilog/layer_stage.sv
test/layer_stage_sva.sv
test/layer_stage_checker.sv
test/layer_stage_tb.sv

//--- run.sh
#!/bin/sh
# Build the layer stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module layer_stage_tb \
  -f compile.f -o layer_stage_sim \
  && ./obj_dir/layer_stage_sim | tee /dev/stderr | grep "ALL CHECKS PASSED" > /dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- test/layer_stage_tb.sv
//////////////////////////////////////////////////////////////////////
// Layer stage testbench
// Clock, reset, frame table and the loop that applies it
// DUT and checker instances, closing summary
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "layer_consts.svh"

module layer_stage_tb;

  localparam int NUM_ROWS      = 9;
  localparam int DRAIN_TIMEOUT = 100;
  localparam int IDLE_CYCLES   = 12;

  // One frame of stimulus
  typedef struct packed {
    int                 len;
    layer_pkg::sample_t bias;
    layer_pkg::sample_t data_base;
    layer_pkg::sample_t data_step;
    layer_pkg::sample_t tap_base;
    layer_pkg::sample_t tap_step;
    logic               rnd;
  } frame_row_t;

  logic                clk;
  logic                reset;
  logic                first;
  layer_pkg::sample_t  data;
  layer_pkg::tap_vec_t taps;
  layer_pkg::sample_t  bias;
  layer_pkg::sample_t  data_out;
  layer_pkg::sample_t  data_out_pre;
  logic                out_valid;

  int         error_count;
  int         valid_count;
  int         pending;
  int         tb_errors;
  int         seed;
  frame_row_t rows [NUM_ROWS];
  string      row_names [NUM_ROWS];

  always #5 clk = ~clk;

  layer_stage UUT (
    .clk          (clk),
    .reset        (reset),
    .first        (first),
    .data         (data),
    .taps         (taps),
    .bias         (bias),
    .data_out     (data_out),
    .data_out_pre (data_out_pre),
    .out_valid    (out_valid)
  );

  layer_stage_checker result_check (
    .clk          (clk),
    .reset        (reset),
    .first        (first),
    .data         (data),
    .taps         (taps),
    .bias         (bias),
    .data_out     (data_out),
    .data_out_pre (data_out_pre),
    .out_valid    (out_valid),
    .error_count  (error_count),
    .valid_count  (valid_count),
    .pending      (pending)
  );

  task automatic add_row(input int r, input string name, input int len, input int b,
                         input int d0, input int ds, input int t0, input int ts,
                         input logic rnd);
    row_names[r]        = name;
    rows[r].len         = len;
    rows[r].bias        = layer_pkg::sample_t'(b);
    rows[r].data_base   = layer_pkg::sample_t'(d0);
    rows[r].data_step   = layer_pkg::sample_t'(ds);
    rows[r].tap_base    = layer_pkg::sample_t'(t0);
    rows[r].tap_step    = layer_pkg::sample_t'(ts);
    rows[r].rnd         = rnd;
  endtask

  // Data is base + k*step, tap of neuron i is base + i*step
  task automatic load_table();
    //     row  name                  len  bias    data    dstep   tap     tstep   rnd
    add_row(0, "small_values",         6, 'h0010, 'h0100, 'h0040, 'h0020, 'h0010, 1'b0);
    add_row(1, "sigmoid_clamp_high",   6, 'h0100, 'h0400, 'h0000, 'h0100, 'h0080, 1'b0);
    add_row(2, "sigmoid_clamp_low",    6, 'hff00, 'h0400, 'h0000, 'hff00, 'hffc0, 1'b0);
    add_row(3, "saturate_positive",    6, 'h0000, 'h1000, 'h0000, 'h1000, 'h0100, 1'b0);
    add_row(4, "saturate_negative",    6, 'h0000, 'h1000, 'h0000, 'hf000, 'hff00, 1'b0);
    add_row(5, "long_frame",          10, 'hffc0, 'hff80, 'h0020, 'h0040, 'hffe0, 1'b0);
    add_row(6, "random_short",         8, 'h0020, 'h0000, 'h0000, 'h0000, 'h0000, 1'b1);
    add_row(7, "random_long",         12, 'hffe0, 'h0000, 'h0000, 'h0000, 'h0000, 1'b1);
    add_row(8, "linear_region",        7, 'h0000, 'h0020, 'h0008, 'h0100, 'hff80, 1'b0);
  endtask

  // Roughly plus or minus 8.0 in Q8.8
  task automatic random_sample(output layer_pkg::sample_t v);
    v = layer_pkg::sample_t'($random(seed) % 2048);
  endtask

  task automatic apply_frame(input int r);
    layer_pkg::sample_t  d;
    layer_pkg::sample_t  v;
    layer_pkg::tap_vec_t t;
    for (int k = 0; k < rows[r].len; k++) begin
      if (rows[r].rnd) begin
        random_sample(d);
        for (int i = 0; i < `LAYER_NUM_NEURONS; i++) begin
          random_sample(v);
          t[(`LAYER_NUM_NEURONS - 1 - i) * `LAYER_SAMPLE_W +: `LAYER_SAMPLE_W] = v;
        end
      end else begin
        d = layer_pkg::sample_t'(int'(rows[r].data_base) + int'(rows[r].data_step) * k);
        for (int i = 0; i < `LAYER_NUM_NEURONS; i++) begin
          v = layer_pkg::sample_t'(int'(rows[r].tap_base) + int'(rows[r].tap_step) * i);
          t[(`LAYER_NUM_NEURONS - 1 - i) * `LAYER_SAMPLE_W +: `LAYER_SAMPLE_W] = v;
        end
      end
      @(posedge clk);
      first <= (k == 0);
      data  <= d;
      taps  <= t;
      // The closing edge of the previous frame still sees its bias
      if (k == 1) begin
        bias <= rows[r].bias;
      end
    end
  endtask

  // Samples ahead of the first pulse belong to no frame
  task automatic apply_stray_samples();
    repeat (2) begin
      @(posedge clk);
      data <= layer_pkg::sample_t'('h0300);
      taps <= {`LAYER_NUM_NEURONS{16'h0100}};
    end
  endtask

  task automatic close_last_frame();
    @(posedge clk);
    first <= 1'b1;
    data  <= '0;
    taps  <= '0;
    @(posedge clk);
    first <= 1'b0;
  endtask

  task automatic wait_for_drain();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while ((pending != 0 || out_valid) && cycles < DRAIN_TIMEOUT);
    if (cycles >= DRAIN_TIMEOUT) begin
      tb_errors++;
      $display("Timeout: results still pending after %0d cycles", DRAIN_TIMEOUT);
    end
    // Quiet cycles catch a late or extra out_valid
    for (int i = 0; i < IDLE_CYCLES; i++) begin
      @(posedge clk);
    end
  endtask

  initial begin
    seed      = 32'h1db3;
    tb_errors = 0;
    clk       = 1'b0;
    reset     = 1'b1;
    first     = 1'b0;
    data      = '0;
    taps      = '0;
    bias      = '0;
    load_table();
    // Frame 0 is the empty frame opened by the first pulse
    for (int r = 0; r < NUM_ROWS; r++) begin
      $display("frame %0d: %s", r + 1, row_names[r]);
    end
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    apply_stray_samples();
    for (int r = 0; r < NUM_ROWS; r++) begin
      apply_frame(r);
    end
    close_last_frame();
    wait_for_drain();
    if (valid_count != `LAYER_NUM_NEURONS * (NUM_ROWS + 1)) begin
      tb_errors++;
      $display("Saw %0d out_valid cycles, %0d frames should give %0d", valid_count,
               NUM_ROWS + 1, `LAYER_NUM_NEURONS * (NUM_ROWS + 1));
    end
    $display("Errors: checker %0d, testbench %0d, out_valid cycles %0d",
             error_count, tb_errors, valid_count);
    if (error_count + tb_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/layer_stage_checker.sv
//////////////////////////////////////////////////////////////////////
// Layer stage checker
// Reference model of the frame sums, bias add and hard sigmoid
// Expected-result queue compared on every out_valid cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "layer_consts.svh"

module layer_stage_checker (
  input  logic                clk,
  input  logic                reset,
  input  logic                first,
  input  layer_pkg::sample_t  data,
  input  layer_pkg::tap_vec_t taps,
  input  layer_pkg::sample_t  bias,
  input  layer_pkg::sample_t  data_out,
  input  layer_pkg::sample_t  data_out_pre,
  input  logic                out_valid,
  output int                  error_count,
  output int                  valid_count,
  output int                  pending
);

  localparam longint PRE_MAX = (longint'(1) <<< (`LAYER_SAMPLE_W - 1)) - 1;
  localparam longint PRE_MIN = -(longint'(1) <<< (`LAYER_SAMPLE_W - 1));

  typedef struct packed {
    int                 cyc;
    int                 frame;
    int                 neuron;
    layer_pkg::sample_t pre;
    layer_pkg::sample_t act;
  } expect_t;

  expect_t            exp_q [$];
  expect_t            e_new;
  expect_t            e_chk;
  layer_pkg::acc_t    acc_m [`LAYER_NUM_NEURONS];
  layer_pkg::acc_t    term;
  layer_pkg::sample_t pre_prev;
  longint             base;
  logic               started;
  int                 cyc;
  int                 frame_idx;

  initial begin
    error_count = 0;
    valid_count = 0;
    pending     = 0;
    cyc         = 0;
  end

  // Q8.8 product with the fraction bits dropped
  function automatic layer_pkg::acc_t mac_term(input layer_pkg::sample_t d,
                                               input layer_pkg::sample_t t);
    longint p;
    p = longint'(d) * longint'(t);
    return layer_pkg::acc_t'(p >>> `LAYER_FRAC_BITS);
  endfunction

  function automatic layer_pkg::sample_t sat_pre(input longint v);
    longint c;
    c = (v > PRE_MAX) ? PRE_MAX : (v < PRE_MIN) ? PRE_MIN : v;
    return layer_pkg::sample_t'(c);
  endfunction

  // x/4 + 0.5 clamped to [0, 1]
  function automatic layer_pkg::sample_t hard_sigmoid(input layer_pkg::sample_t pre);
    longint y;
    y = (longint'(pre) >>> `LAYER_SIG_SHIFT) + `LAYER_SIG_HALF;
    y = (y < 0) ? 0 : (y > `LAYER_SIG_ONE) ? `LAYER_SIG_ONE : y;
    return layer_pkg::sample_t'(y);
  endfunction

  // t0 sits in the top bits
  function automatic layer_pkg::sample_t tap_of(input layer_pkg::tap_vec_t t, input int i);
    return t[(`LAYER_NUM_NEURONS - 1 - i) * `LAYER_SAMPLE_W +: `LAYER_SAMPLE_W];
  endfunction

  task automatic compare_value(input string sig, input expect_t e,
                               input layer_pkg::sample_t expv, input layer_pkg::sample_t actv);
    if (actv !== expv) begin
      error_count++;
      $display("ERR frame%0d_neuron%0d_%s expected %0d actual %0d",
               e.frame, e.neuron, sig, expv, actv);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Model, fed with the inputs seen at each rising edge
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (reset) begin
      started   = 1'b0;
      frame_idx = 0;
      exp_q.delete();
      for (int i = 0; i < `LAYER_NUM_NEURONS; i++) begin
        acc_m[i] = '0;
      end
    end else begin
      if (first) begin
        // Results leave three edges after first is sampled
        for (int i = 0; i < `LAYER_NUM_NEURONS; i++) begin
          base         = started ? longint'(acc_m[i]) : 0;
          e_new.cyc    = cyc + 3 + i;
          e_new.frame  = frame_idx;
          e_new.neuron = i;
          e_new.pre    = sat_pre(base + longint'(bias));
          e_new.act    = hard_sigmoid(e_new.pre);
          exp_q.push_back(e_new);
        end
        frame_idx++;
        started = 1'b1;
      end
      for (int i = 0; i < `LAYER_NUM_NEURONS; i++) begin
        term     = mac_term(data, tap_of(taps, i));
        acc_m[i] = first ? term : layer_pkg::acc_t'(acc_m[i] + term);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Compare at the falling edge, outputs settled
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (reset) begin
      if (out_valid) begin
        error_count++;
        $display("out_valid is high during reset at cycle %0d", cyc);
      end
    end else if (out_valid) begin
      valid_count++;
      if (exp_q.size() == 0) begin
        error_count++;
        $display("Extra out_valid at cycle %0d with no result due", cyc);
      end else begin
        e_chk = exp_q.pop_front();
        if (e_chk.cyc != cyc) begin
          error_count++;
          $display("Frame %0d neuron %0d came out at cycle %0d instead of cycle %0d",
                   e_chk.frame, e_chk.neuron, cyc, e_chk.cyc);
        end
        // data_out_pre runs one cycle ahead of data_out
        compare_value("data_out_pre", e_chk, e_chk.pre, pre_prev);
        compare_value("data_out", e_chk, e_chk.act, data_out);
      end
    end else if (exp_q.size() > 0 && exp_q[0].cyc <= cyc) begin
      e_chk = exp_q.pop_front();
      error_count++;
      $display("Missing out_valid for frame %0d neuron %0d at cycle %0d",
               e_chk.frame, e_chk.neuron, cyc);
    end
    pending  = exp_q.size();
    pre_prev = data_out_pre;
  end

endmodule

`default_nettype wire

//--- test/layer_stage_sva.sv
//////////////////////////////////////////////////////////////////////
// Assertions on the output stage
// Quiet output after reset, six valid cycles per frame_done,
// activation range, bind into layer_output
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module layer_stage_sva (
  input  logic               clk,
  input  logic               reset,
  input  logic               frame_done,
  input  logic               out_valid,
  input  layer_pkg::sample_t data_out
);

  // Recent frame_done history, newest in bit 0
  logic [6:0] done_hist;

  always_ff @(posedge clk) begin
    if (reset) begin
      done_hist <= '0;
    end else begin
      done_hist <= {done_hist[5:0], frame_done};
    end
  end

  a_reset_quiet: assert property (@(posedge clk) reset |=> !out_valid)
    else $error("out_valid high after a reset cycle");

  // Valid exactly while a frame_done lies 2 to 7 cycles back
  a_six_valid: assert property (@(posedge clk) disable iff (reset)
    out_valid == (|done_hist[6:1]))
    else $error("out_valid does not follow frame_done for six cycles");

  a_act_range: assert property (@(posedge clk) disable iff (reset)
    (data_out >= 0) && (data_out <= 256))
    else $error("data_out outside the sigmoid range");

endmodule

bind layer_output layer_stage_sva output_sva (
  .clk        (clk),
  .reset      (reset),
  .frame_done (frame_done),
  .out_valid  (out_valid),
  .data_out   (data_out)
);

`default_nettype wire

//--- verilog/layer_stage.sv
//////////////////////////////////////////////////////////////////////
// layer_stage
// Top level of one accelerator layer
// Neuron array feeding the output line and activation
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module layer_stage (
  input  logic                clk,
  input  logic                reset,
  input  logic                first,
  input  layer_pkg::sample_t  data,
  input  layer_pkg::tap_vec_t taps,
  input  layer_pkg::sample_t  bias,
  output layer_pkg::sample_t  data_out,
  output layer_pkg::sample_t  data_out_pre,
  output logic                out_valid
);

  layer_pkg::sum_vec_t sums;
  layer_pkg::sample_t  bias_r;
  logic                frame_done;

  // Accumulation over each frame
  layer_neurons neurons (
    .clk        (clk),
    .reset      (reset),
    .first      (first),
    .data       (data),
    .taps       (taps),
    .bias       (bias),
    .sums       (sums),
    .bias_r     (bias_r),
    .frame_done (frame_done)
  );

  // Serial readout with bias and sigmoid
  layer_output outputs (
    .clk          (clk),
    .reset        (reset),
    .sums         (sums),
    .bias_r       (bias_r),
    .frame_done   (frame_done),
    .data_out     (data_out),
    .data_out_pre (data_out_pre),
    .out_valid    (out_valid)
  );

endmodule

`default_nettype wire

//--- verilog/layer_output.sv
//////////////////////////////////////////////////////////////////////
// layer_output
// Output line draining the six frame sums, neuron 0 first
// Bias add with saturation to Q8.8 (data_out_pre)
// Hard-sigmoid activation (data_out) and out_valid strobe
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "layer_consts.svh"

module layer_output (
  input  logic                clk,
  input  logic                reset,
  input  layer_pkg::sum_vec_t sums,
  input  layer_pkg::sample_t  bias_r,
  input  logic                frame_done,
  output layer_pkg::sample_t  data_out,
  output layer_pkg::sample_t  data_out_pre,
  output logic                out_valid
);

  // Head goes straight to the adder on the load cycle
  localparam int LINE_LEN   = `LAYER_NUM_NEURONS - 1;
  localparam int CNT_W      = $clog2(`LAYER_NUM_NEURONS);
  localparam int SAMPLE_MAX = (1 << (`LAYER_SAMPLE_W - 1)) - 1;
  localparam int SAMPLE_MIN = -(1 << (`LAYER_SAMPLE_W - 1));

  typedef logic signed [`LAYER_ACC_W:0] wide_t;

  localparam wide_t              SAT_MAX  = wide_t'(SAMPLE_MAX);
  localparam wide_t              SAT_MIN  = wide_t'(SAMPLE_MIN);
  localparam layer_pkg::sample_t SIG_HALF = layer_pkg::sample_t'(`LAYER_SIG_HALF);
  localparam layer_pkg::sample_t SIG_ONE  = layer_pkg::sample_t'(`LAYER_SIG_ONE);

  layer_pkg::out_state_t state;
  logic [CNT_W-1:0]      count;
  layer_pkg::acc_t       line [LINE_LEN];
  layer_pkg::acc_t       head;
  wide_t                 biased;
  layer_pkg::sample_t    pre_sat;
  layer_pkg::sample_t    sig_lin;
  layer_pkg::sample_t    sig_out;
  logic                  pre_valid;

  //////////////////////////////////////////////////////////////////////
  // Drain control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= layer_pkg::OUT_IDLE;
      count     <= '0;
      pre_valid <= 1'b0;
    end else begin
      pre_valid <= 1'b0;
      case (state)
        layer_pkg::OUT_IDLE: begin
          if (frame_done) begin
            state     <= layer_pkg::OUT_DRAIN;
            count     <= CNT_W'(LINE_LEN);
            pre_valid <= 1'b1;
          end
        end
        layer_pkg::OUT_DRAIN: begin
          pre_valid <= 1'b1;
          count     <= count - 1'b1;
          if (count == CNT_W'(1)) begin
            state <= layer_pkg::OUT_IDLE;
          end
        end
        default: state <= layer_pkg::OUT_IDLE;
      endcase
    end
  end

  // Neurons 1 to 5 wait here and shift toward the head
  always_ff @(posedge clk) begin
    if (reset) begin
      line <= '{default: '0};
    end else if (frame_done) begin
      line[0] <= sums.s1;
      line[1] <= sums.s2;
      line[2] <= sums.s3;
      line[3] <= sums.s4;
      line[4] <= sums.s5;
    end else if (state == layer_pkg::OUT_DRAIN) begin
      for (int i = 0; i < LINE_LEN - 1; i++) begin
        line[i] <= line[i+1];
      end
      line[LINE_LEN-1] <= '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Bias add and activation
  //////////////////////////////////////////////////////////////////////

  assign head   = frame_done ? sums.s0 : line[0];
  assign biased = wide_t'(head) + wide_t'(bias_r);

  // Clip to the Q8.8 range
  assign pre_sat = (biased > SAT_MAX) ? layer_pkg::sample_t'(SAT_MAX) :
                   (biased < SAT_MIN) ? layer_pkg::sample_t'(SAT_MIN) :
                                        layer_pkg::sample_t'(biased);

  // x/4 + 0.5, then clamp to [0, 1]
  assign sig_lin = (data_out_pre >>> `LAYER_SIG_SHIFT) + SIG_HALF;
  assign sig_out = sig_lin[`LAYER_SAMPLE_W-1] ? '0 :
                   (sig_lin > SIG_ONE)        ? SIG_ONE : sig_lin;

  always_ff @(posedge clk) begin
    if (reset) begin
      data_out_pre <= '0;
    end else if (frame_done || state == layer_pkg::OUT_DRAIN) begin
      data_out_pre <= pre_sat;
    end
  end

  // Activation stage trails the pre-activation by one cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      data_out  <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= pre_valid;
      if (pre_valid) begin
        data_out <= sig_out;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/layer_neurons.sv
//////////////////////////////////////////////////////////////////////
// layer_neurons
// Input register stage for data, taps, first and bias
// Six MAC neurons on the shared stream
// Frame capture of the sums and the frame bias, frame_done pulse
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "layer_consts.svh"

module layer_neurons (
  input  logic                clk,
  input  logic                reset,
  input  logic                first,
  input  layer_pkg::sample_t  data,
  input  layer_pkg::tap_vec_t taps,
  input  layer_pkg::sample_t  bias,
  output layer_pkg::sum_vec_t sums,
  output layer_pkg::sample_t  bias_r,
  output logic                frame_done
);

  layer_pkg::sample_t  data_q;
  layer_pkg::tap_vec_t taps_q;
  layer_pkg::sample_t  bias_q;
  logic                first_q;
  logic                started;

  layer_pkg::sample_t  tap_arr [`LAYER_NUM_NEURONS];
  layer_pkg::acc_t     acc_arr [`LAYER_NUM_NEURONS];
  layer_pkg::sum_vec_t frame_tot;

  //////////////////////////////////////////////////////////////////////
  // Input registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      data_q  <= '0;
      taps_q  <= '0;
      bias_q  <= '0;
      first_q <= 1'b0;
    end else begin
      data_q  <= data;
      taps_q  <= taps;
      bias_q  <= bias;
      first_q <= first;
    end
  end

  // Samples ahead of the first frame belong to no frame
  always_ff @(posedge clk) begin
    if (reset) begin
      started <= 1'b0;
    end else if (first_q) begin
      started <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Neuron array
  //////////////////////////////////////////////////////////////////////

  assign tap_arr[0] = taps_q.t0;
  assign tap_arr[1] = taps_q.t1;
  assign tap_arr[2] = taps_q.t2;
  assign tap_arr[3] = taps_q.t3;
  assign tap_arr[4] = taps_q.t4;
  assign tap_arr[5] = taps_q.t5;

  for (genvar i = 0; i < `LAYER_NUM_NEURONS; i++) begin : g_neuron
    neuron neuron_inst (
      .clk     (clk),
      .reset   (reset),
      .restart (first_q),
      .data    (data_q),
      .tap     (tap_arr[i]),
      .acc     (acc_arr[i])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // Frame capture
  //////////////////////////////////////////////////////////////////////

  assign frame_tot.s0 = acc_arr[0];
  assign frame_tot.s1 = acc_arr[1];
  assign frame_tot.s2 = acc_arr[2];
  assign frame_tot.s3 = acc_arr[3];
  assign frame_tot.s4 = acc_arr[4];
  assign frame_tot.s5 = acc_arr[5];

  // Accumulators still hold the closed frame on the restart edge
  always_ff @(posedge clk) begin
    if (reset) begin
      sums       <= '0;
      bias_r     <= '0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= first_q;
      if (first_q) begin
        sums   <= started ? frame_tot : '0;
        bias_r <= bias_q;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/neuron.sv
//////////////////////////////////////////////////////////////////////
// neuron
// Multiply-accumulate of the data stream with one tap
// Restart loads the new product in place of the running sum
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "layer_consts.svh"

module neuron (
  input  logic               clk,
  input  logic               reset,
  input  logic               restart,
  input  layer_pkg::sample_t data,
  input  layer_pkg::sample_t tap,
  output layer_pkg::acc_t    acc
);

  layer_pkg::product_t prod;
  layer_pkg::acc_t     term;

  // Q8.8 times Q8.8 gives Q16.16
  assign prod = data * tap;

  // Arithmetic shift right by the fraction bits, kept as Q16.8.
  // The top 24 bits of the 32-bit product are exactly that shift.
  assign term = prod[`LAYER_FRAC_BITS +: `LAYER_ACC_W];

  // Sum wraps on overflow, the output stage saturates later
  always_ff @(posedge clk) begin
    if (reset) begin
      acc <= '0;
    end else if (restart) begin
      acc <= term;
    end else begin
      acc <= acc + term;
    end
  end

endmodule

`default_nettype wire

//--- verilog/layer_pkg.sv
//////////////////////////////////////////////////////////////////////
// Layer stage types
// Sample, product and accumulator vectors
// Per-neuron tap and frame-sum bundles
// Output line state
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "layer_consts.svh"

package layer_pkg;

  // Q8.8 data, tap, bias or output value
  typedef logic signed [`LAYER_SAMPLE_W-1:0] sample_t;

  // Full product of two samples, Q16.16
  typedef logic signed [2*`LAYER_SAMPLE_W-1:0] product_t;

  // Running frame sum, Q16.8
  typedef logic signed [`LAYER_ACC_W-1:0] acc_t;

  // One tap per neuron
  typedef struct packed {
    sample_t t0;
    sample_t t1;
    sample_t t2;
    sample_t t3;
    sample_t t4;
    sample_t t5;
  } tap_vec_t;

  // Totals of a closed frame, neuron 0 first
  typedef struct packed {
    acc_t s0;
    acc_t s1;
    acc_t s2;
    acc_t s3;
    acc_t s4;
    acc_t s5;
  } sum_vec_t;

  typedef enum logic {
    OUT_IDLE,
    OUT_DRAIN
  } out_state_t;

endpackage

`default_nettype wire

//--- verilog/layer_consts.svh
//////////////////////////////////////////////////////////////////////
// Layer stage constants
// Neuron count and Q8.8 data path widths
// Hard-sigmoid offset, ceiling and slope shift
//////////////////////////////////////////////////////////////////////

`ifndef LAYER_CONSTS_SVH
`define LAYER_CONSTS_SVH

// Neurons sharing the serial data stream
`define LAYER_NUM_NEURONS 6

// Q8.8 samples, taps and outputs
`define LAYER_SAMPLE_W    16
`define LAYER_FRAC_BITS   8

// Accumulator headroom over a sample
`define LAYER_ACC_W       24

// Hard sigmoid y = clamp(x/4 + 0.5, 0, 1) in Q8.8
`define LAYER_SIG_HALF    128
`define LAYER_SIG_ONE     256
`define LAYER_SIG_SHIFT   2

`endif
